// File: design/trig_pkg.sv
/* fixed-point types, coefficients and pipeline latencies for the polar to rectangular
   converter, imported by every design module */
package trig_pkg;

	// number format: signed 27 bits with 8 fraction bits
	localparam int FIX_WIDTH = 27;
	localparam int FRAC_BITS = 8;

	typedef logic signed [FIX_WIDTH-1:0] fix_t;
	// full product of two fix_t values
	typedef logic signed [2*FIX_WIDTH-1:0] prod_t;

	// sine coefficients, scaled by 2^FRAC_BITS
	// 4/pi
	localparam fix_t COEF_4_PI = fix_t'(326);
	// 4/pi^2
	localparam fix_t COEF_4_PI2 = fix_t'(104);
	// refinement weight 0.225
	localparam fix_t COEF_REFINE = fix_t'(58);

	// angle constants in radians
	localparam fix_t PI_FIX = fix_t'(804);
	localparam fix_t HALF_PI_FIX = fix_t'(402);

	// latencies in clock cycles
	localparam int MULT_LATENCY = 2;
	localparam int SINE_LATENCY = 10;
	localparam int TOP_LATENCY = SINE_LATENCY + MULT_LATENCY;

	// slot index into the magnitude delay line
	typedef logic [$clog2(SINE_LATENCY)-1:0] mag_ptr_t;

	// narrow a product back to fix_t
	// keep bits 34..8, round half up on bit 7, wrap at 27 bits
	function automatic fix_t round_fix(input prod_t p);
		return fix_t'(p[FRAC_BITS+FIX_WIDTH-1:FRAC_BITS] + p[FRAC_BITS-1]);
	endfunction

endpackage

// File: design/fix_mult.sv
/* two-stage signed fixed-point multiplier, result rounded to fix_t
   and valid MULT_LATENCY cycles after the operands */
`timescale 1ns/1ps

module fix_mult import trig_pkg::*; (
	input logic clk,
	input fix_t a,
	input fix_t b,
	output fix_t result
);

	// full-width product of the current operands
	prod_t prod_full;
	// stage 1 register
	prod_t prod_r;

	// both operands sign extended before the multiply
	// so the full 54-bit product is exact
	assign prod_full = prod_t'(a) * prod_t'(b);

	// stage 1 holds the exact product
	// stage 2 holds the rounded, narrowed value
	// pure datapath so no reset needed
	always_ff @(posedge clk) begin
		prod_r <= prod_full;
		result <= round_fix(prod_r);
	end

endmodule

// File: design/sine_approx.sv
/* parabolic sine pipeline with phase offset and wrap into plus or minus pi;
   PHASE of pi/2 turns it into a cosine, result follows in_valid by SINE_LATENCY */
`timescale 1ns/1ps

module sine_approx import trig_pkg::*; #(
	parameter fix_t PHASE = fix_t'(0)
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input fix_t angle,
	output logic out_valid,
	output fix_t result
);

	// phase offset and wrap, combinational ahead of cycle 1
	fix_t shifted;
	fix_t wrapped;

	// cycle 1
	fix_t a_r;

	// 4/pi branch, raw product then rounded
	prod_t p_4pi;
	fix_t t_4pi;
	fix_t t_4pi_d;

	// a squared from the multiplier, cycle 3
	fix_t a_sq;
	prod_t p_4pi2;
	// 4/pi^2 term, cycle 4
	fix_t t_4pi2;

	// sign of a, carried to cycle 4
	logic [2:0] sgn_d;

	// first estimate, cycle 5
	fix_t est;
	// est carried to cycles 6..9
	fix_t est_d [4];

	// refinement
	fix_t est_sq;
	fix_t est_norm;
	fix_t diff;
	prod_t p_refine;
	fix_t t_refine;

	// one valid bit per pipeline stage
	logic [SINE_LATENCY-1:0] vld_sr;

	// add the phase, fold back if past +pi
	assign shifted = angle + PHASE;
	assign wrapped = (shifted > PI_FIX) ? fix_t'(shifted - PI_FIX - PI_FIX) : shifted;

	// a^2, operands at cycle 1, ready at cycle 3
	fix_mult sq_mult (
		.clk(clk),
		.a(a_r),
		.b(a_r),
		.result(a_sq)
	);

	// est^2, operands at cycle 5, ready at cycle 7
	fix_mult est_mult (
		.clk(clk),
		.a(est),
		.b(est),
		.result(est_sq)
	);

	// constant products formed in place
	assign p_4pi2 = prod_t'(a_sq) * prod_t'(COEF_4_PI2);
	assign p_refine = prod_t'(diff) * prod_t'(COEF_REFINE);

	// signed square of the estimate
	// negative est flips the square so the refinement keeps its sign
	// est_d[1] lines up with est_sq at cycle 7
	assign est_norm = est_d[1][FIX_WIDTH-1] ? fix_t'(-est_sq) : est_sq;

	// datapath registers, no reset
	always_ff @(posedge clk) begin
		// cycle 1
		a_r <= wrapped;

		// 4/pi product, registered twice to match the multiplier
		p_4pi <= prod_t'(a_r) * prod_t'(COEF_4_PI);
		t_4pi <= round_fix(p_4pi);
		// held one more cycle for the 4/pi^2 term
		t_4pi_d <= t_4pi;

		// cycle 4
		t_4pi2 <= round_fix(p_4pi2);
		sgn_d <= {sgn_d[1:0], a_r[FIX_WIDTH-1]};

		// cycle 5
		// negative a adds the square term, positive a subtracts it
		if (sgn_d[2]) begin
			est <= t_4pi_d + t_4pi2;
		end else begin
			est <= t_4pi_d - t_4pi2;
		end

		est_d[0] <= est;
		for (int i = 1; i < 4; i++) begin
			est_d[i] <= est_d[i-1];
		end

		// cycle 8
		diff <= est_norm - est_d[1];
		// cycle 9
		t_refine <= round_fix(p_refine);
		// cycle 10, est from cycle 5 added back
		result <= t_refine + est_d[3];
	end

	// valid tracking
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[SINE_LATENCY-2:0], in_valid};
		end
	end

	assign out_valid = vld_sr[SINE_LATENCY-1];

endmodule

// File: design/polar_combine.sv
/* holds each magnitude until its sine and cosine arrive, then scales them into x and y;
   out_valid follows sin_cos_valid by MULT_LATENCY cycles */
`timescale 1ns/1ps

module polar_combine import trig_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input fix_t magnitude,
	input logic sin_cos_valid,
	input fix_t sin_val,
	input fix_t cos_val,
	output logic out_valid,
	output fix_t x,
	output fix_t y
);

	// magnitude delay line
	// written on in_valid, read on sin_cos_valid
	// SINE_LATENCY slots cover a full sine pipeline of back-to-back samples
	fix_t mag_mem [SINE_LATENCY];
	mag_ptr_t wr_ptr;
	mag_ptr_t rd_ptr;
	fix_t mag_rd;

	// valid delay through the multipliers
	logic [MULT_LATENCY-1:0] vld_sr;

	// step a slot index, wrapping at the line depth
	function automatic mag_ptr_t ptr_inc(input mag_ptr_t p);
		if (p == mag_ptr_t'(SINE_LATENCY - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	// the oldest magnitude still waiting
	assign mag_rd = mag_mem[rd_ptr];

	// x = magnitude * cos
	fix_mult x_mult (
		.clk(clk),
		.a(mag_rd),
		.b(cos_val),
		.result(x)
	);

	// y = magnitude * sin
	fix_mult y_mult (
		.clk(clk),
		.a(mag_rd),
		.b(sin_val),
		.result(y)
	);

	// storage only, no reset
	always_ff @(posedge clk) begin
		if (in_valid) begin
			mag_mem[wr_ptr] <= magnitude;
		end
	end

	// slot pointers and valid bits
	// the read side advances exactly once per sample, as the sine pipeline
	// emits one valid per in_valid in order
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			vld_sr <= '0;
		end else begin
			if (in_valid) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (sin_cos_valid) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			vld_sr <= {vld_sr[MULT_LATENCY-2:0], sin_cos_valid};
		end
	end

	assign out_valid = vld_sr[MULT_LATENCY-1];

endmodule

// File: design/polar_to_rect.sv
/* top of the polar to rectangular converter: sine and cosine evaluators feed the combiner,
   x and y valid TOP_LATENCY cycles after in_valid */
`timescale 1ns/1ps

module polar_to_rect import trig_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input fix_t angle,
	input fix_t magnitude,
	output logic out_valid,
	output fix_t x,
	output fix_t y
);

	// evaluator results
	fix_t sin_val;
	fix_t cos_val;
	// shared valid, both evaluators have the same latency
	logic sin_cos_valid;

	// sin(angle)
	sine_approx #(
		.PHASE(fix_t'(0))
	) sin_eval (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.angle(angle),
		.out_valid(sin_cos_valid),
		.result(sin_val)
	);

	// cos(angle) as sin(angle + pi/2)
	// valid left open, sin_eval already marks the same cycle
	sine_approx #(
		.PHASE(HALF_PI_FIX)
	) cos_eval (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.angle(angle),
		.out_valid(),
		.result(cos_val)
	);

	// magnitude scaling
	polar_combine combine (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.magnitude(magnitude),
		.sin_cos_valid(sin_cos_valid),
		.sin_val(sin_val),
		.cos_val(cos_val),
		.out_valid(out_valid),
		.x(x),
		.y(y)
	);

endmodule

// File: verif/polar_to_rect_chk.sv
/* assertions on valid timing and output values of the converter top,
   attached to every polar_to_rect by the bind below */
`timescale 1ns/1ps

module polar_to_rect_chk import trig_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic out_valid,
	input fix_t x,
	input fix_t y
);

	// one output per input, fixed latency
	property p_latency;
		@(posedge clk) disable iff (!rst_n)
			out_valid == $past(in_valid, TOP_LATENCY);
	endproperty

	// nothing leaves the pipe in reset
	property p_quiet_in_reset;
		@(posedge clk) !rst_n |-> !out_valid;
	endproperty

	// valid results are fully driven
	property p_known_outputs;
		@(posedge clk) disable iff (!rst_n)
			out_valid |-> !$isunknown({x, y});
	endproperty

	a_latency: assert property (p_latency)
		else $error("out_valid does not follow in_valid by the pipeline latency");
	a_quiet_in_reset: assert property (p_quiet_in_reset)
		else $error("out_valid high during reset");
	a_known_outputs: assert property (p_known_outputs)
		else $error("x or y unknown while out_valid is high");

endmodule

bind polar_to_rect polar_to_rect_chk chk0 (
	.clk(clk),
	.rst_n(rst_n),
	.in_valid(in_valid),
	.out_valid(out_valid),
	.x(x),
	.y(y)
);

// File: verif/tb_polar_to_rect.sv
/* testbench for the polar to rectangular converter; plays the stimulus file once with
   random idle gaps and once back to back, checking x, y and latency of every output */
`timescale 1ns/1ps

module tb_polar_to_rect import trig_pkg::*; ();

	localparam int NUM_SAMPLES = 24;
	localparam int DRAIN_LIMIT = TOP_LATENCY + 20;

	logic clk;
	logic rst_n;
	logic in_valid;
	fix_t angle;
	fix_t magnitude;
	logic out_valid;
	fix_t x;
	fix_t y;

	// four words per sample: angle, magnitude, x, y
	logic [FIX_WIDTH-1:0] stim_mem [0:NUM_SAMPLES*4-1];
	// index of the sample on the inputs, travels with in_valid
	int cur_idx;

	// scoreboard
	fix_t exp_x_q[$];
	fix_t exp_y_q[$];
	int issue_q[$];
	int cycle;
	int recv_count;

	logic [31:0] lfsr_state;

	polar_to_rect dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.angle(angle),
		.magnitude(magnitude),
		.out_valid(out_valid),
		.x(x),
		.y(y)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h8020_0003;
		end
		return n;
	endfunction

	// idle cycles before the next strobe, two bits from the lfsr
	task automatic random_gap(output int gap);
		logic b0;
		logic b1;
		b0 = lfsr_state[0];
		lfsr_state = next_lfsr(lfsr_state);
		b1 = lfsr_state[0];
		lfsr_state = next_lfsr(lfsr_state);
		gap = {b1, b0};
	endtask

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped on first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic send_sample(input int idx);
		@(posedge clk);
		in_valid <= 1'b1;
		angle <= stim_mem[idx*4];
		magnitude <= stim_mem[idx*4+1];
		cur_idx <= idx;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	// inputs and outputs both sampled before this edge's updates
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (rst_n && in_valid) begin
			exp_x_q.push_back(stim_mem[cur_idx*4+2]);
			exp_y_q.push_back(stim_mem[cur_idx*4+3]);
			issue_q.push_back(cycle);
		end
		if (out_valid) begin
			if (issue_q.size() == 0) begin
				report_failure("out_valid went high with no sample in flight");
			end else begin
				check_value("latency", 32'(cycle - issue_q.pop_front()), TOP_LATENCY);
				check_value("x", 32'(x) & 32'h7ff_ffff,
					32'(exp_x_q.pop_front()) & 32'h7ff_ffff);
				check_value("y", 32'(y) & 32'h7ff_ffff,
					32'(exp_y_q.pop_front()) & 32'h7ff_ffff);
				recv_count <= recv_count + 1;
			end
		end
	end

	initial begin
		int gap;
		int waited;
		rst_n = 1'b0;
		in_valid = 1'b0;
		angle = '0;
		magnitude = '0;
		cur_idx = 0;
		cycle = 0;
		recv_count = 0;
		lfsr_state = 32'h3b39_9ffd;
		$readmemh("verif/polar_stimulus.txt", stim_mem);

		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		// quiet period, monitor flags any stray out_valid
		idle_cycles(20);

		// first pass with random gaps
		for (int i = 0; i < NUM_SAMPLES; i++) begin
			send_sample(i);
			random_gap(gap);
			// every sixth sample runs straight into the next one
			if (i % 6 == 5) begin
				gap = 0;
			end
			idle_cycles(gap);
		end
		idle_cycles(1);

		// second pass back to back, fills the pipeline
		for (int i = 0; i < NUM_SAMPLES; i++) begin
			send_sample(i);
		end
		idle_cycles(1);

		waited = 0;
		while (recv_count != 2 * NUM_SAMPLES && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (recv_count != 2 * NUM_SAMPLES) begin
			report_failure("timeout: out_valid never arrived for every sample sent");
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

// File: verif/polar_stimulus.txt
// columns: angle magnitude expected_x expected_y
// 27-bit two's complement hex, 8 fraction bits
// special angles 0, +-pi/2, +-pi
0000000 0000100 0000100 0000000
0000192 0000100 7FFFFFE 0000100
7FFFE6E 0000100 0000000 7FFFF00
0000324 0000100 7FFFF00 7FFFFFE
7FFFCDC 0000100 7FFFF00 0000002
0000000 0000200 0000200 0000000
// just above pi/2, cosine path wraps past pi
000019A 0000100 7FFFFF9 00000FF
00001F4 0000100 7FFFFA2 00000ED
000025A 0000100 7FFFF4D 00000B5
00002BF 0000100 7FFFF13 0000061
// spread of angles and magnitudes
0000008 00003E8 00003E4 000001F
7FFFCE4 0000280 7FFFD80 7FFFFEF
7FFFE76 000012C 0000009 7FFFED4
0000062 000004D 0000047 000001D
7FFFD3E 00004D2 7FFFB8A 7FFFE3B
7FFFED0 7FFFF00 7FFFFA0 00000ED
00000C8 0000800 00005A8 00005A8
7FFFDA4 000002D 7FFFFE0 7FFFFE1
7FFFF36 000014D 00000EB 7FFFF15
000012D 00001F4 00000BD 00001CB
7FFFE09 0000001 0000000 7FFFFFF
7FFFF9B 0000FA0 0000E58 7FFF9F5
000025A 7FFFD44 00001E9 7FFFE11
00001F4 0000000 0000000 0000000

// File: sim.f
design/trig_pkg.sv
design/fix_mult.sv
design/sine_approx.sv
design/polar_combine.sv
design/polar_to_rect.sv
verif/polar_to_rect_chk.sv
verif/tb_polar_to_rect.sv

// File: run_sim.sh
#!/bin/sh
# build and run the converter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_polar_to_rect -o sim_tb \
	&& ./obj_dir/sim_tb | grep -q "NO ERRORS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
